// File: design/accel_pkg.sv
package accel_pkg;

  ////////////////////////////////////////////////////////////
  // layer geometry
  ////////////////////////////////////////////////////////////
  localparam int N_IN       = 8;  // input samples per layer
  localparam int MAX_K      = 4;  // kernel taps, also weight regs
  localparam int MAX_STRIDE = 4;

  // instruction word fields
  localparam int LT_MSB   = 27;  // layer_type
  localparam int LT_LSB   = 24;
  localparam int KS_MSB   = 23;  // kernel_size
  localparam int KS_LSB   = 20;
  localparam int ST_MSB   = 19;  // stride
  localparam int ST_LSB   = 16;
  localparam int RELU_BIT = 15;

  ////////////////////////////////////////////////////////////
  // word address map
  ////////////////////////////////////////////////////////////
  localparam int ADR_INST     = 'h00;  // write starts a layer
  localparam int ADR_STATUS   = 'h01;
  localparam int ADR_IN_BASE  = 'h08;  // 8 input samples
  localparam int ADR_W_BASE   = 'h10;  // 4 weights
  localparam int ADR_RES_BASE = 'h20;  // 8 results

  // status word bits
  localparam int ST_BUSY    = 0;
  localparam int ST_DONE    = 1;
  localparam int ST_ERR     = 2;
  localparam int ST_CNT_LSB = 8;  // result count, 11:8

  typedef logic signed [7:0]  sample_t;  // input sample or weight
  typedef logic signed [19:0] acc_t;     // accumulator / result

  typedef enum logic [3:0] {
    LT_CONV   = 4'd0,
    LT_POOL   = 4'd1,  // max only
    LT_ACT    = 4'd2,  // relu forced on
    LT_BYPASS = 4'd4
  } layer_type_t;

  typedef struct packed {
    layer_type_t layer_type;
    logic [2:0]  kernel_size;
    logic [2:0]  stride;
    logic        relu_en;
    logic [3:0]  out_count;  // outputs this layer produces
  } layer_cmd_t;

endpackage

// File: design/accel_ifs.sv
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// decoder -> engine command channel
////////////////////////////////////////////////////////////
interface layer_cmd_if import accel_pkg::*; ();

  logic       start;  // one-cycle pulse
  layer_cmd_t cmd;    // valid with start
  logic       busy;   // from engine

  modport source (
    output start,
    output cmd,
    input  busy
  );

  modport sink (
    input  start,
    input  cmd,
    output busy
  );

endinterface

////////////////////////////////////////////////////////////
// engine -> result buffer write channel
////////////////////////////////////////////////////////////
interface result_if import accel_pkg::*; ();

  logic       wr;     // one-cycle write strobe
  logic [2:0] idx;
  acc_t       data;
  logic       last;   // with the final wr
  logic       clear;  // layer start

  modport source (
    output wr,
    output idx,
    output data,
    output last,
    output clear
  );

  modport sink (
    input wr,
    input idx,
    input data,
    input last,
    input clear
  );

endinterface

// File: design/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import accel_pkg::*; #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load,       // instruction write, ack cycle
  input  logic [DATA_WIDTH-1:0] inst_word,
  output logic                  err,
  layer_cmd_if.source           cmd
);

  logic [DATA_WIDTH-1:0] inst_reg;  // last legal word
  logic [3:0]            type_in;
  logic [3:0]            ks_in;
  logic [3:0]            st_in;
  logic                  legal;
  logic                  start_q;
  layer_cmd_t            cmd_d;

  // raw fields of the incoming word, full 4-bit width for the range checks
  assign type_in = inst_word[LT_MSB:LT_LSB];
  assign ks_in   = inst_word[KS_MSB:KS_LSB];
  assign st_in   = inst_word[ST_MSB:ST_LSB];

  always_comb begin
    case (type_in)
      LT_CONV, LT_POOL, LT_ACT, LT_BYPASS: legal = 1'b1;
      default:                             legal = 1'b0;  // 3 and 5..15
    endcase
    if (ks_in == 4'd0 || ks_in > 4'(MAX_K)) legal = 1'b0;
    if (st_in == 4'd0 || st_in > 4'(MAX_STRIDE)) legal = 1'b0;
  end

  // an illegal word leaves the previous command in place
  always_ff @(posedge clk) begin
    if (load && legal) inst_reg <= inst_word;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      start_q <= 1'b0;
      err     <= 1'b0;
    end else begin
      start_q <= load & legal;  // high the cycle after the ack
      if (load) err <= ~legal;  // sticky until the next instruction write
    end
  end

  ////////////////////////////////////////////////////////////
  // field extraction from the latched word
  ////////////////////////////////////////////////////////////
  always_comb begin
    cmd_d.layer_type  = layer_type_t'(inst_reg[LT_MSB:LT_LSB]);
    cmd_d.kernel_size = inst_reg[KS_LSB +: 3];  // legal range fits 3 bits
    cmd_d.stride      = inst_reg[ST_LSB +: 3];
    cmd_d.relu_en     = inst_reg[RELU_BIT];
    // sliding windows give (N - k) / s + 1 outputs
    if (cmd_d.layer_type == LT_CONV || cmd_d.layer_type == LT_POOL)
      cmd_d.out_count = 4'((N_IN - int'(cmd_d.kernel_size)) / int'(cmd_d.stride) + 1);
    else
      cmd_d.out_count = 4'(N_IN);  // elementwise
  end

  assign cmd.start = start_q;
  assign cmd.cmd   = cmd_d;

endmodule

// File: design/layer_engine.sv
`timescale 1ns/1ps

module layer_engine import accel_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  layer_cmd_if.sink   cmd,
  input  sample_t     inputs [N_IN],
  input  sample_t     weights [MAX_K],
  result_if.source    res
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_RUN,  // one tap or one sample per cycle
    S_FIN   // last write on the bus
  } state_t;

  state_t            state;
  layer_cmd_t        cmd_q;    // command held for the whole layer
  logic [2:0]        i;        // output index
  logic [1:0]        j;        // tap index
  acc_t              acc;      // running sum or max
  logic [2:0]        src_idx;
  sample_t           x;
  sample_t           w;
  logic signed [15:0] prod;
  acc_t              x_ext;
  acc_t              tap_val;
  acc_t              out_val;
  logic              is_win;   // conv or pool
  logic              relu_on;
  logic              last_tap;
  logic              last_out;
  logic              emit;

  ////////////////////////////////////////////////////////////
  // operand fetch
  ////////////////////////////////////////////////////////////
  assign is_win  = (cmd_q.layer_type == LT_CONV) || (cmd_q.layer_type == LT_POOL);
  // window start plus tap, elementwise layers walk i directly
  assign src_idx = is_win ? 3'(i * cmd_q.stride + 3'(j)) : i;
  assign x       = inputs[src_idx];
  assign w       = weights[j];
  assign prod    = x * w;  // signed 8x8
  assign x_ext   = acc_t'(x);

  assign last_tap = (3'(j) == cmd_q.kernel_size - 3'd1);
  assign last_out = ({1'b0, i} == cmd_q.out_count - 4'd1);
  assign emit     = (state == S_RUN) && (!is_win || last_tap);

  always_comb begin
    case (cmd_q.layer_type)
      LT_CONV: tap_val = (j == 2'd0) ? acc_t'(prod) : acc + acc_t'(prod);
      LT_POOL: tap_val = (j == 2'd0 || x_ext > acc) ? x_ext : acc;
      default: tap_val = x_ext;  // act, bypass
    endcase
  end

  // act always clamps, bypass never does
  assign relu_on = (cmd_q.layer_type == LT_ACT) ||
                   (cmd_q.relu_en && cmd_q.layer_type != LT_BYPASS);
  assign out_val = (relu_on && tap_val[$bits(acc_t)-1]) ? '0 : tap_val;

  ////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= S_IDLE;
      i         <= '0;
      j         <= '0;
      res.wr    <= 1'b0;
      res.last  <= 1'b0;
      res.clear <= 1'b0;
    end else begin
      res.wr    <= 1'b0;  // strobes default low
      res.last  <= 1'b0;
      res.clear <= 1'b0;
      case (state)
        S_IDLE: begin
          if (cmd.start) begin
            state     <= S_RUN;
            i         <= '0;
            j         <= '0;
            res.clear <= 1'b1;  // wipe old results
          end
        end
        S_RUN: begin
          if (emit) begin
            res.wr   <= 1'b1;
            res.last <= last_out;
            j        <= '0;
            if (last_out) state <= S_FIN;
            else          i     <= i + 3'd1;
          end else begin
            j <= j + 2'd1;  // next tap
          end
        end
        default: state <= S_IDLE;  // S_FIN, busy drops next
      endcase
    end
  end

  // datapath regs
  always_ff @(posedge clk) begin
    if (state == S_IDLE && cmd.start) cmd_q <= cmd.cmd;
    if (state == S_RUN) acc <= tap_val;
    if (emit) begin
      res.idx  <= i;
      res.data <= out_val;
    end
  end

  assign cmd.busy = (state != S_IDLE);  // through the last write

endmodule

// File: design/result_buffer.sv
`timescale 1ns/1ps

module result_buffer import accel_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  result_if.sink     res,
  input  logic [2:0] rd_idx,
  output acc_t       rd_data,
  output logic [3:0] count,
  output logic       done
);

  acc_t            mem [N_IN];  // result storage
  logic [N_IN-1:0] valid;       // written in this layer

  ////////////////////////////////////////////////////////////
  // flags and count
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid <= '0;
      count <= '0;
      done  <= 1'b0;
    end else if (res.clear) begin  // new layer
      valid <= '0;
      count <= '0;
      done  <= 1'b0;
    end else if (res.wr) begin
      valid[res.idx] <= 1'b1;
      count          <= count + 4'd1;
      if (res.last) done <= 1'b1;  // cycle after last
    end
  end

  always_ff @(posedge clk) begin
    if (res.wr) mem[res.idx] <= res.data;
  end

  // stale slots read zero
  assign rd_data = valid[rd_idx] ? mem[rd_idx] : '0;

endmodule

// File: design/accel_cu_top.sv
`timescale 1ns/1ps

module accel_cu_top import accel_pkg::*; #(
  parameter int ADR_WIDTH  = 6,
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [ADR_WIDTH-1:0]  adr,
  input  logic [DATA_WIDTH-1:0] dat_w,
  output logic [DATA_WIDTH-1:0] dat_r,
  output logic                  ack
);

  localparam int IW = $clog2(N_IN);   // input / result index bits
  localparam int KW = $clog2(MAX_K);  // weight index bits
  localparam logic [ADR_WIDTH-1:0] A_INST   = ADR_WIDTH'(ADR_INST);
  localparam logic [ADR_WIDTH-1:0] A_STATUS = ADR_WIDTH'(ADR_STATUS);
  localparam logic [ADR_WIDTH-1:0] A_IN     = ADR_WIDTH'(ADR_IN_BASE);
  localparam logic [ADR_WIDTH-1:0] A_W      = ADR_WIDTH'(ADR_W_BASE);
  localparam logic [ADR_WIDTH-1:0] A_RES    = ADR_WIDTH'(ADR_RES_BASE);

  layer_cmd_if lcmd ();
  result_if    res_bus ();

  sample_t               in_reg [N_IN];
  sample_t               w_reg [MAX_K];
  logic                  req;
  logic                  sel_inst, sel_status, sel_in, sel_w, sel_res;
  logic                  busy;     // start pending or engine running
  logic                  wr_en;
  logic                  load;
  logic                  err;
  logic                  rb_done;
  logic                  done;
  logic [3:0]            count;
  acc_t                  rd_data;
  logic [DATA_WIDTH-1:0] status;

  ////////////////////////////////////////////////////////////
  // wishbone slave
  ////////////////////////////////////////////////////////////
  assign req        = cyc & stb;
  assign sel_inst   = (adr == A_INST);
  assign sel_status = (adr == A_STATUS);
  assign sel_in     = (adr[ADR_WIDTH-1:IW] == A_IN[ADR_WIDTH-1:IW]);
  assign sel_w      = (adr[ADR_WIDTH-1:KW] == A_W[ADR_WIDTH-1:KW]);
  assign sel_res    = (adr[ADR_WIDTH-1:IW] == A_RES[ADR_WIDTH-1:IW]);

  assign busy = lcmd.busy | lcmd.start;

  // instruction write waits out a running layer, everything else acks at once
  always_ff @(posedge clk or posedge rst) begin
    if (rst) ack <= 1'b0;
    else     ack <= req & ~ack & ~(we & sel_inst & busy);
  end

  assign wr_en = ack & we;  // master holds adr/dat_w through ack
  assign load  = wr_en & sel_inst;

  // operands frozen while a layer runs
  always_ff @(posedge clk) begin
    if (wr_en && !busy) begin
      if (sel_in) in_reg[adr[IW-1:0]] <= sample_t'(dat_w[7:0]);
      if (sel_w)  w_reg[adr[KW-1:0]]  <= sample_t'(dat_w[7:0]);
    end
  end

  ////////////////////////////////////////////////////////////
  // status and read mux
  ////////////////////////////////////////////////////////////
  // a stale done is hidden behind err or a new layer
  assign done = rb_done & ~err & ~busy;

  always_comb begin
    status                      = '0;
    status[ST_BUSY]             = busy;
    status[ST_DONE]             = done;
    status[ST_ERR]              = err;
    status[ST_CNT_LSB +: 4]     = count;
  end

  always_comb begin
    if (sel_status)   dat_r = status;
    else if (sel_in)  dat_r = DATA_WIDTH'(in_reg[adr[IW-1:0]]);  // sign extended
    else if (sel_w)   dat_r = DATA_WIDTH'(w_reg[adr[KW-1:0]]);
    else if (sel_res) dat_r = DATA_WIDTH'(rd_data);
    else              dat_r = '0;  // instruction is write only
  end

  ////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////
  inst_decoder #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_inst_decoder (
    .clk       (clk),
    .rst       (rst),
    .load      (load),
    .inst_word (dat_w),
    .err       (err),
    .cmd       (lcmd)
  );

  layer_engine i_layer_engine (
    .clk     (clk),
    .rst     (rst),
    .cmd     (lcmd),
    .inputs  (in_reg),
    .weights (w_reg),
    .res     (res_bus)
  );

  result_buffer i_result_buffer (
    .clk     (clk),
    .rst     (rst),
    .res     (res_bus),
    .rd_idx  (adr[IW-1:0]),
    .rd_data (rd_data),
    .count   (count),
    .done    (rb_done)
  );

endmodule

// File: tb/accel_cu_properties.sv
`timescale 1ns/1ps

module accel_cu_properties (
  input logic clk,
  input logic rst,
  input logic cyc,
  input logic stb,
  input logic ack,
  input logic start,
  input logic busy,
  input logic res_wr,
  input logic done,
  input logic err
);

  ////////////////////////////////////////////////////////////
  // wishbone handshake
  ////////////////////////////////////////////////////////////
  ack_in_req: assert property (@(posedge clk) disable iff (rst) ack |-> (cyc && stb))
    else $error("ack raised outside a cyc/stb request");
  ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else $error("ack held for two cycles");

  // internal channels
  start_pulse: assert property (@(posedge clk) disable iff (rst) start |=> !start)
    else $error("start longer than one cycle");
  wr_in_layer: assert property (@(posedge clk) disable iff (rst) res_wr |-> busy)
    else $error("result write while engine idle");
  done_xor_err: assert property (@(posedge clk) disable iff (rst) !(done && err))
    else $error("done and err high together");

endmodule

bind accel_cu_top accel_cu_properties i_accel_cu_properties (
  .clk    (clk),
  .rst    (rst),
  .cyc    (cyc),
  .stb    (stb),
  .ack    (ack),
  .start  (lcmd.start),
  .busy   (lcmd.busy),
  .res_wr (res_bus.wr),
  .done   (done),
  .err    (err)
);

// File: tb/tb_accel_cu.sv
`timescale 1ns/1ps

module tb_accel_cu import accel_pkg::*; ();

  localparam int ACK_LIMIT  = 200;  // cycles per bus transfer
  localparam int POLL_LIMIT = 100;  // status reads per layer

  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] inst2;  // back-to-back rows only
    logic [31:0] wts;    // weight t in byte t
    logic [1:0]  mode;   // 0 plain, 1 input writes while busy, 2 back to back
    logic        neg;    // force every input negative
  } row_t;

  logic        clk;
  logic        rst;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [5:0]  adr;
  logic [31:0] dat_w;
  logic [31:0] dat_r;
  logic        ack;

  row_t       rows [$];
  int         in_val [N_IN];   // inputs as the model sees them
  int         w_val [MAX_K];
  acc_t       exp_res [N_IN];  // survives illegal rows
  logic [3:0] exp_count;
  logic       exp_err;
  int         seed;

  accel_cu_top #(
    .ADR_WIDTH  (6),
    .DATA_WIDTH (32)
  ) i_accel_cu_top (
    .clk   (clk),
    .rst   (rst),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  ////////////////////////////////////////////////////////////
  // wishbone master
  ////////////////////////////////////////////////////////////
  task automatic bus_cycle(input logic wr, input logic [5:0] a, input logic [31:0] d,
                           output logic [31:0] q, output int waited);
    int n;
    n = 0;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= wr;
    adr   <= a;
    dat_w <= d;
    @(negedge clk);  // sample mid-cycle
    while (!ack) begin
      n++;
      if (n > ACK_LIMIT) begin
        $display("timeout, no ack from the slave at address 0x%0h", a);
        stop_with_failure();
      end
      @(negedge clk);
    end
    q      = dat_r;
    waited = n;
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic write_reg(input logic [5:0] a, input logic [31:0] d);
    logic [31:0] q;
    int          n;
    bus_cycle(1'b1, a, d, q, n);
  endtask

  task automatic read_reg(input logic [5:0] a, output logic [31:0] q);
    int n;
    bus_cycle(1'b0, a, '0, q, n);
  endtask

  task automatic poll_status(output logic [31:0] st);
    int n;
    n = 0;
    read_reg(6'(ADR_STATUS), st);
    while (!(st[ST_DONE] || st[ST_ERR])) begin
      n++;
      if (n > POLL_LIMIT) begin
        $display("timeout, status never showed done or err");
        stop_with_failure();
      end
      read_reg(6'(ADR_STATUS), st);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_result(input int idx, input acc_t exp, input acc_t got);
    if (got !== exp) begin
      $display("FAILED at %0t: result[%0d] expected %0d got %0d", $time, idx, exp, got);
      stop_with_failure();
    end
  endtask

  task automatic check_status(input logic e_done, input logic e_err, input logic [3:0] e_cnt,
                              input logic [31:0] st);
    if (st[ST_DONE] !== e_done || st[ST_ERR] !== e_err || st[ST_CNT_LSB +: 4] !== e_cnt) begin
      $display("FAILED at %0t: status done/err/count expected %0b/%0b/%0d got %0b/%0b/%0d",
               $time, e_done, e_err, e_cnt, st[ST_DONE], st[ST_ERR], st[ST_CNT_LSB +: 4]);
      stop_with_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////
  task automatic compute_expected(input logic [31:0] inst);
    logic [3:0] lt;
    logic       relu;
    logic       legal;
    int         k;
    int         st;
    int         n_out;
    int         v;
    lt    = inst[LT_MSB:LT_LSB];
    k     = int'(inst[KS_MSB:KS_LSB]);
    st    = int'(inst[ST_MSB:ST_LSB]);
    relu  = inst[RELU_BIT];
    legal = (lt == LT_CONV || lt == LT_POOL || lt == LT_ACT || lt == LT_BYPASS) &&
            k >= 1 && k <= MAX_K && st >= 1 && st <= MAX_STRIDE;
    exp_err = ~legal;
    if (legal) begin  // illegal words keep old results and count
      n_out     = (lt == LT_CONV || lt == LT_POOL) ? (N_IN - k) / st + 1 : N_IN;
      exp_count = 4'(n_out);
      for (int o = 0; o < N_IN; o++) begin
        v = 0;  // unused slots read zero
        if (o < n_out) begin
          case (lt)
            LT_CONV: begin
              for (int t = 0; t < k; t++)
                v += in_val[o * st + t] * w_val[t];
            end
            LT_POOL: begin
              v = in_val[o * st];
              for (int t = 1; t < k; t++)
                if (in_val[o * st + t] > v) v = in_val[o * st + t];
            end
            default: v = in_val[o];  // elementwise
          endcase
          if ((lt == LT_ACT || (relu && lt != LT_BYPASS)) && v < 0) v = 0;
        end
        exp_res[o] = acc_t'(v);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] make_inst(input logic [3:0] t, input logic [3:0] k,
                                            input logic [3:0] s, input logic relu);
    logic [31:0] w;
    w                  = '0;
    w[LT_MSB:LT_LSB]   = t;
    w[KS_MSB:KS_LSB]   = k;
    w[ST_MSB:ST_LSB]   = s;
    w[RELU_BIT]        = relu;
    return w;
  endfunction

  task automatic add_row(input logic [31:0] inst, input logic [31:0] inst2,
                         input logic [31:0] wts, input logic [1:0] mode, input logic neg);
    rows.push_back('{inst, inst2, wts, mode, neg});
  endtask

  task automatic build_table();
    // conv, kernel 1..4, stride 1..3
    add_row(make_inst(LT_CONV, 4'd1, 4'd1, 1'b0), '0, 32'h0000_0005, 2'd0, 1'b0);
    add_row(make_inst(LT_CONV, 4'd2, 4'd1, 1'b0), '0, 32'h0000_fd07, 2'd0, 1'b0);
    add_row(make_inst(LT_CONV, 4'd3, 4'd2, 1'b1), '0, 32'h0002_81f9, 2'd0, 1'b0);
    add_row(make_inst(LT_CONV, 4'd4, 4'd1, 1'b0), '0, 32'h7f80_0cf4, 2'd0, 1'b0);
    add_row(make_inst(LT_CONV, 4'd4, 4'd3, 1'b1), '0, 32'h11ee_05fb, 2'd0, 1'b0);
    add_row(make_inst(LT_CONV, 4'd2, 4'd3, 1'b0), '0, 32'h0000_40c0, 2'd0, 1'b0);
    add_row(make_inst(LT_CONV, 4'd3, 4'd1, 1'b1), '0, 32'h0003_fe09, 2'd0, 1'b0);
    add_row(make_inst(LT_CONV, 4'd1, 4'd2, 1'b0), '0, 32'h0000_00fc, 2'd0, 1'b0);
    // max pooling, some rows all negative
    add_row(make_inst(LT_POOL, 4'd2, 4'd2, 1'b0), '0, '0, 2'd0, 1'b1);
    add_row(make_inst(LT_POOL, 4'd3, 4'd1, 1'b0), '0, '0, 2'd0, 1'b0);
    add_row(make_inst(LT_POOL, 4'd2, 4'd1, 1'b1), '0, '0, 2'd0, 1'b1);  // clamps to 0
    add_row(make_inst(LT_POOL, 4'd4, 4'd2, 1'b1), '0, '0, 2'd0, 1'b0);
    add_row(make_inst(LT_POOL, 4'd3, 4'd3, 1'b0), '0, '0, 2'd0, 1'b1);
    // elementwise, unused bits set on bypass
    add_row(make_inst(LT_ACT, 4'd1, 4'd1, 1'b0), '0, '0, 2'd0, 1'b0);
    add_row(make_inst(LT_BYPASS, 4'd1, 4'd1, 1'b1) | 32'h8000_00a5, '0, '0, 2'd0, 1'b0);
    // illegal words
    add_row(make_inst(4'd3, 4'd2, 4'd1, 1'b0), '0, '0, 2'd0, 1'b0);
    add_row(make_inst(LT_CONV, 4'd0, 4'd1, 1'b0), '0, '0, 2'd0, 1'b0);
    add_row(make_inst(LT_POOL, 4'd5, 4'd1, 1'b0), '0, '0, 2'd0, 1'b0);
    add_row(make_inst(LT_CONV, 4'd2, 4'd0, 1'b0), '0, '0, 2'd0, 1'b0);
    // traffic during a running layer
    add_row(make_inst(LT_CONV, 4'd4, 4'd1, 1'b0), '0, 32'h0af6_1e03, 2'd1, 1'b0);
    add_row(make_inst(LT_CONV, 4'd4, 4'd1, 1'b1), make_inst(LT_POOL, 4'd2, 4'd2, 1'b0),
            32'h0af6_1e03, 2'd2, 1'b0);
  endtask

  task automatic run_row(input row_t r);
    logic [31:0] q;
    logic [31:0] model_inst;
    int          waited;
    sample_t     s;
    for (int i = 0; i < N_IN; i++) begin
      s = sample_t'($random(seed));
      if (r.neg) s[7] = 1'b1;
      in_val[i] = int'(s);
      write_reg(6'(ADR_IN_BASE + i), 32'(s));
    end
    for (int t = 0; t < MAX_K; t++) begin
      w_val[t] = int'(sample_t'(r.wts[8 * t +: 8]));
      write_reg(6'(ADR_W_BASE + t), {24'h0, r.wts[8 * t +: 8]});
    end
    bus_cycle(1'b1, 6'(ADR_INST), r.inst, q, waited);
    model_inst = r.inst;
    if (r.mode == 2'd1) begin
      // operands frozen, these must not reach the layer
      // samples 6 and 7 feed only the last windows, read well after these writes
      write_reg(6'(ADR_IN_BASE + 7), 32'(in_val[7] ^ 'h5a));
      write_reg(6'(ADR_IN_BASE + 6), 32'(~in_val[6]));
    end else if (r.mode == 2'd2) begin
      bus_cycle(1'b1, 6'(ADR_INST), r.inst2, q, waited);  // stalls behind layer one
      if (waited < 4) begin
        $display("second instruction acked after %0d cycles, layer one still running", waited);
        stop_with_failure();
      end
      model_inst = r.inst2;
    end
    compute_expected(model_inst);
    poll_status(q);
    check_status(~exp_err, exp_err, exp_count, q);
    for (int k = 0; k < N_IN; k++) begin
      read_reg(6'(ADR_RES_BASE + k), q);
      check_result(k, exp_res[k], acc_t'(q[19:0]));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    seed      = 95;
    rst       = 1'b1;
    cyc       = 1'b0;
    stb       = 1'b0;
    we        = 1'b0;
    adr       = '0;
    dat_w     = '0;
    exp_count = '0;
    exp_err   = 1'b0;
    foreach (exp_res[k]) exp_res[k] = '0;
    build_table();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    foreach (rows[r]) run_row(rows[r]);
    $display("Simulation passed");
    $finish;
  end

endmodule

// File: src.f
design/accel_pkg.sv
design/accel_ifs.sv
design/inst_decoder.sv
design/layer_engine.sv
design/result_buffer.sv
design/accel_cu_top.sv
tb/accel_cu_properties.sv
tb/tb_accel_cu.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, then run; exit status carries the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_accel_cu -f src.f -o sim_tb \
  && ./obj_dir/sim_tb \
  || { echo "verilator build or run returned an error"; exit 1; }
